// File: hw/dmaPkg.sv
// DMA register block package: widths, register offsets, mode bits and bus structs
package dmaPkg;

  localparam int numChannels = 4;

  typedef logic [15:0] dmaAddrT;
  typedef logic [15:0] dmaCountT;
  typedef logic [7:0]  dmaByteT;
  typedef logic [3:0]  regOffsetT;
  typedef logic [1:0]  channelIdT;

  // Host register map above the per-channel address and count pairs
  localparam regOffsetT offsetStatus       = 4'd8;
  localparam regOffsetT offsetSingleMask   = 4'd10;
  localparam regOffsetT offsetMode         = 4'd11;
  localparam regOffsetT offsetClearPointer = 4'd12;
  localparam regOffsetT offsetMasterClear  = 4'd13;
  localparam regOffsetT offsetClearMask    = 4'd14;
  localparam regOffsetT offsetAllMask      = 4'd15;

  // Mode byte fields, bits 1:0 name the channel
  localparam int modeAutoInitBit  = 4;
  localparam int modeDecrementBit = 5;

  typedef struct packed {
    logic      write;
    logic      read;
    regOffsetT offset;
    dmaByteT   data;
  } hostReqT;

  typedef struct packed {
    logic      strobe;
    channelIdT channel;
  } serviceReqT;

  // One-cycle command pulses for a single channel
  typedef struct packed {
    logic    writeAddr;
    logic    writeCount;
    logic    readAddr;
    logic    readCount;
    logic    highByte;
    logic    writeMode;
    logic    autoInit;
    logic    decrement;
    logic    setMask;
    logic    clearMask;
    logic    clearTc;
    logic    masterClear;
    logic    step;
    dmaByteT data;
  } chanCmdT;

  typedef struct packed {
    dmaAddrT  addr;
    dmaCountT count;
    logic     tc;
  } chanViewT;

  typedef struct packed {
    logic    valid;
    dmaByteT data;
  } readRspT;

  typedef struct packed {
    logic    valid;
    dmaAddrT addr;
    logic    tc;
  } busOutT;

endpackage

// File: hw/dmaCommandDecoder.sv
// Host and service strobe decoder with byte pointer, per-channel command pulses
`timescale 1ns/1ps

module dmaCommandDecoder #(
  parameter int NumChannels = dmaPkg::numChannels
) (
  input  logic                 dif,
  input  logic                 reset,
  input  dmaPkg::hostReqT      hostReq,
  input  dmaPkg::serviceReqT   serviceReq,
  output dmaPkg::chanCmdT      chanCmd [NumChannels],
  // {channel[1:0], count, highByte, status}
  output logic [4:0]           readSel,
  output logic                 readPending,
  output dmaPkg::serviceReqT   stepSel
);
  import dmaPkg::*;

  chanCmdT   nextCmd [NumChannels];
  logic      bytePointer;
  logic      chanAccess;
  logic      clearPointer;
  channelIdT readChan;
  logic      readCount;
  logic      readHigh;
  logic      readAny;
  logic      statusRead;

  // Offsets 0..7 address a channel's address or count pair
  assign chanAccess   = (hostReq.write || hostReq.read) && !hostReq.offset[3];
  assign clearPointer = hostReq.write &&
                        (hostReq.offset == offsetClearPointer ||
                         hostReq.offset == offsetMasterClear);

  always_comb
  begin
    for (int i = 0; i < NumChannels; i++)
    begin
      nextCmd[i]           = '0;
      nextCmd[i].highByte  = bytePointer;
      nextCmd[i].data      = hostReq.data;
      nextCmd[i].autoInit  = hostReq.data[modeAutoInitBit];
      nextCmd[i].decrement = hostReq.data[modeDecrementBit];
      if (chanAccess && hostReq.offset[2:1] == channelIdT'(i))
      begin
        nextCmd[i].writeAddr  = hostReq.write && !hostReq.offset[0];
        nextCmd[i].writeCount = hostReq.write && hostReq.offset[0];
        nextCmd[i].readAddr   = hostReq.read && !hostReq.offset[0];
        nextCmd[i].readCount  = hostReq.read && hostReq.offset[0];
      end
      if (hostReq.write)
      begin
        case (hostReq.offset)
          offsetSingleMask:
            if (hostReq.data[1:0] == channelIdT'(i))
            begin
              nextCmd[i].setMask   = hostReq.data[2];
              nextCmd[i].clearMask = !hostReq.data[2];
            end
          offsetMode:
            nextCmd[i].writeMode = hostReq.data[1:0] == channelIdT'(i);
          offsetMasterClear:
            nextCmd[i].masterClear = 1'b1;
          offsetClearMask:
            nextCmd[i].clearMask = 1'b1;
          offsetAllMask:
          begin
            nextCmd[i].setMask   = hostReq.data[i];
            nextCmd[i].clearMask = !hostReq.data[i];
          end
          default: ;
        endcase
      end
      // Status read clears every TC flag
      nextCmd[i].clearTc = hostReq.read && hostReq.offset == offsetStatus;
      nextCmd[i].step    = serviceReq.strobe && serviceReq.channel == channelIdT'(i);
    end
  end

  always_ff @(posedge dif)
  begin
    if (reset)
    begin
      for (int i = 0; i < NumChannels; i++)
        chanCmd[i] <= '0;
      stepSel     <= '0;
      bytePointer <= 1'b0;
    end
    else
    begin
      chanCmd <= nextCmd;
      stepSel <= serviceReq;
      if (clearPointer)
        bytePointer <= 1'b0;
      else if (chanAccess)
        bytePointer <= !bytePointer;
    end
  end

  // Read selection follows the registered command pulses
  always_comb
  begin
    readChan  = '0;
    readCount = 1'b0;
    readHigh  = 1'b0;
    readAny   = 1'b0;
    for (int i = 0; i < NumChannels; i++)
    begin
      if (chanCmd[i].readAddr || chanCmd[i].readCount)
      begin
        readChan  = channelIdT'(i);
        readCount = chanCmd[i].readCount;
        readHigh  = chanCmd[i].highByte;
        readAny   = 1'b1;
      end
    end
  end

  assign statusRead  = chanCmd[0].clearTc;
  assign readSel     = {readChan, readCount, readHigh, statusRead};
  assign readPending = readAny || statusRead;

endmodule

// File: hw/dmaChannel.sv
// One DMA channel: base and current address and count, mode, mask and TC flag
`timescale 1ns/1ps

module dmaChannel (
  input  logic             dif,
  input  logic             reset,
  input  dmaPkg::chanCmdT  chanCmd,
  output dmaPkg::chanViewT chanView,
  output logic             masked
);
  import dmaPkg::*;

  dmaAddrT  baseAddr;
  dmaAddrT  currAddr;
  dmaCountT baseCount;
  dmaCountT currCount;
  logic     autoInit;
  logic     decrement;
  logic     maskBit;
  logic     tcFlag;
  logic     stepEn;
  logic     atTc;

  // Replace one byte of a 16-bit register
  function automatic logic [15:0] loadByte(
    input logic [15:0] value,
    input dmaByteT     data,
    input logic        high
  );
    logic [15:0] result;
    result = value;
    if (high)
      result[15:8] = data;
    else
      result[7:0] = data;
    return result;
  endfunction

  assign stepEn = chanCmd.step && !maskBit;
  // Count already exhausted before this step
  assign atTc   = currCount == '0;

  always_ff @(posedge dif)
  begin
    if (reset || chanCmd.masterClear)
    begin
      baseAddr  <= '0;
      currAddr  <= '0;
      baseCount <= '0;
      currCount <= '0;
      autoInit  <= 1'b0;
      decrement <= 1'b0;
      maskBit   <= 1'b0;
      tcFlag    <= 1'b0;
    end
    else
    begin
      if (chanCmd.writeAddr)
      begin
        baseAddr <= loadByte(baseAddr, chanCmd.data, chanCmd.highByte);
        currAddr <= loadByte(currAddr, chanCmd.data, chanCmd.highByte);
      end
      if (chanCmd.writeCount)
      begin
        baseCount <= loadByte(baseCount, chanCmd.data, chanCmd.highByte);
        currCount <= loadByte(currCount, chanCmd.data, chanCmd.highByte);
      end
      if (chanCmd.writeMode)
      begin
        autoInit  <= chanCmd.autoInit;
        decrement <= chanCmd.decrement;
      end

      if (stepEn)
      begin
        if (atTc && autoInit)
        begin
          currAddr  <= baseAddr;
          currCount <= baseCount;
        end
        else
        begin
          currAddr  <= decrement ? currAddr - 1'b1 : currAddr + 1'b1;
          currCount <= currCount - 1'b1;
        end
      end

      // Channel masks itself at TC unless it reloads
      if (stepEn && atTc && !autoInit)
        maskBit <= 1'b1;
      else if (chanCmd.setMask)
        maskBit <= 1'b1;
      else if (chanCmd.clearMask)
        maskBit <= 1'b0;

      if (stepEn && atTc)
        tcFlag <= 1'b1;
      else if (chanCmd.clearTc)
        tcFlag <= 1'b0;
    end
  end

  assign chanView = '{addr: currAddr, count: currCount, tc: tcFlag};
  assign masked   = maskBit;

endmodule

// File: hw/dmaOutputStage.sv
// Output registers for host read data and service bus address
`timescale 1ns/1ps

module dmaOutputStage #(
  parameter int NumChannels = dmaPkg::numChannels
) (
  input  logic                   dif,
  input  logic                   reset,
  input  logic [4:0]             readSel,
  input  logic                   readPending,
  input  dmaPkg::chanViewT       chanView [NumChannels],
  input  logic [NumChannels-1:0] masked,
  input  dmaPkg::serviceReqT     stepSel,
  output dmaPkg::readRspT        readRsp,
  output dmaPkg::busOutT         busOut
);
  import dmaPkg::*;

  chanViewT readView;
  chanViewT stepView;
  logic     stepMasked;
  dmaByteT  statusByte;
  dmaByteT  readByte;
  dmaCountT readWord;
  logic     readValid;
  dmaByteT  readData;
  logic     busValid;
  dmaAddrT  busAddr;
  logic     busTc;

  always_comb
  begin
    readView   = '0;
    stepView   = '0;
    stepMasked = 1'b1;
    statusByte = '0;
    for (int i = 0; i < NumChannels; i++)
    begin
      if (readSel[4:3] == channelIdT'(i))
        readView = chanView[i];
      if (stepSel.channel == channelIdT'(i))
      begin
        stepView   = chanView[i];
        stepMasked = masked[i];
      end
      statusByte[i] = chanView[i].tc;
    end
  end

  // Count or address, then byte, status overrides both
  assign readWord = readSel[2] ? readView.count : readView.addr;
  assign readByte = readSel[0] ? statusByte :
                    readSel[1] ? readWord[15:8] : readWord[7:0];

  always_ff @(posedge dif)
  begin
    if (reset)
    begin
      readValid <= 1'b0;
      busValid  <= 1'b0;
    end
    else
    begin
      readValid <= readPending;
      busValid  <= stepSel.strobe && !stepMasked;
    end
  end

  // Pre-step address and TC condition of the stepped channel
  always_ff @(posedge dif)
  begin
    readData <= readByte;
    busAddr  <= stepView.addr;
    busTc    <= stepView.count == '0;
  end

  assign readRsp = '{valid: readValid, data: readData};
  assign busOut  = '{valid: busValid, addr: busAddr, tc: busTc};

endmodule

// File: hw/dmaTop.sv
// DMA register block top: command decoder, channel array and output stage
`timescale 1ns/1ps

module dmaTop #(
  parameter int NumChannels = dmaPkg::numChannels
) (
  input  logic               dif,
  input  logic               reset,
  input  dmaPkg::hostReqT    hostReq,
  input  dmaPkg::serviceReqT serviceReq,
  output dmaPkg::readRspT    readRsp,
  output dmaPkg::busOutT     busOut
);
  import dmaPkg::*;

  chanCmdT                chanCmd [NumChannels];
  chanViewT               chanView [NumChannels];
  logic [NumChannels-1:0] masked;
  logic [4:0]             readSel;
  logic                   readPending;
  serviceReqT             stepSel;

  dmaCommandDecoder #(
    .NumChannels (NumChannels)
  ) u_commandDecoder (
    .dif         (dif),
    .reset       (reset),
    .hostReq     (hostReq),
    .serviceReq  (serviceReq),
    .chanCmd     (chanCmd),
    .readSel     (readSel),
    .readPending (readPending),
    .stepSel     (stepSel)
  );

  for (genvar i = 0; i < NumChannels; i++)
  begin : g_channel
    dmaChannel u_channel (
      .dif      (dif),
      .reset    (reset),
      .chanCmd  (chanCmd[i]),
      .chanView (chanView[i]),
      .masked   (masked[i])
    );
  end

  dmaOutputStage #(
    .NumChannels (NumChannels)
  ) u_outputStage (
    .dif         (dif),
    .reset       (reset),
    .readSel     (readSel),
    .readPending (readPending),
    .chanView    (chanView),
    .masked      (masked),
    .stepSel     (stepSel),
    .readRsp     (readRsp),
    .busOut      (busOut)
  );

endmodule

// File: testbench/dmaTbTasks.svh
// Register access, service strobe and wait tasks with the channel reference model
localparam int waitLimit = 16;

dmaAddrT  modelBaseAddr  [numChannels];
dmaAddrT  modelCurrAddr  [numChannels];
dmaCountT modelBaseCount [numChannels];
dmaCountT modelCurrCount [numChannels];
logic     modelAutoInit  [numChannels];
logic     modelDecrement [numChannels];
logic     modelMask      [numChannels];
logic     modelTc        [numChannels];
logic     modelPointer;

// Byte lane picked by the byte pointer
function automatic logic [15:0] withByte(input logic [15:0] word, input dmaByteT data);
  return modelPointer ? {data, word[7:0]} : {word[15:8], data};
endfunction

task automatic clearModel();
  for (int i = 0; i < numChannels; i++)
  begin
    modelBaseAddr[i]  = '0;
    modelCurrAddr[i]  = '0;
    modelBaseCount[i] = '0;
    modelCurrCount[i] = '0;
    modelAutoInit[i]  = 1'b0;
    modelDecrement[i] = 1'b0;
    modelMask[i]      = 1'b0;
    modelTc[i]        = 1'b0;
  end
  modelPointer = 1'b0;
endtask

// Hold a request for one cycle, then return the inputs to idle
task automatic finishRequest();
  @(posedge dif);
  #1;
  hostReq    = '0;
  serviceReq = '0;
  expReadNow = '0;
  expBusNow  = '0;
endtask

task automatic writeReg(input regOffsetT offset, input dmaByteT data);
  channelIdT ch;
  ch      = offset[2:1];
  hostReq = '{write: 1'b1, read: 1'b0, offset: offset, data: data};
  if (!offset[3] && !offset[0])
  begin
    modelBaseAddr[ch] = withByte(modelBaseAddr[ch], data);
    modelCurrAddr[ch] = withByte(modelCurrAddr[ch], data);
  end
  else if (!offset[3])
  begin
    modelBaseCount[ch] = withByte(modelBaseCount[ch], data);
    modelCurrCount[ch] = withByte(modelCurrCount[ch], data);
  end
  if (!offset[3])
    modelPointer = !modelPointer;
  case (offset)
    offsetSingleMask:
      modelMask[data[1:0]] = data[2];
    offsetMode:
    begin
      modelAutoInit[data[1:0]]  = data[modeAutoInitBit];
      modelDecrement[data[1:0]] = data[modeDecrementBit];
    end
    offsetClearPointer:
      modelPointer = 1'b0;
    offsetMasterClear:
      clearModel();
    offsetClearMask:
      for (int i = 0; i < numChannels; i++)
        modelMask[i] = 1'b0;
    offsetAllMask:
      for (int i = 0; i < numChannels; i++)
        modelMask[i] = data[i];
    default: ;
  endcase
  finishRequest();
endtask

task automatic waitReadValid();
  int n;
  n = 0;
  @(negedge dif);
  while (!readRsp.valid && n < waitLimit)
  begin
    @(negedge dif);
    n++;
  end
  if (!readRsp.valid)
    stopOnError("Timeout: no read response after a host read");
  else
  begin
    @(posedge dif);
    #1;
  end
endtask

// Offsets 0..7 read a channel byte, offset 8 reads status
task automatic readReg(input regOffsetT offset);
  channelIdT ch;
  dmaCountT  word;
  ch               = offset[2:1];
  hostReq          = '{write: 1'b0, read: 1'b1, offset: offset, data: '0};
  expReadNow.valid = 1'b1;
  expReadNow.data  = '0;
  if (offset == offsetStatus)
  begin
    for (int i = 0; i < numChannels; i++)
    begin
      expReadNow.data[i] = modelTc[i];
      modelTc[i]         = 1'b0;
    end
  end
  else
  begin
    word            = offset[0] ? modelCurrCount[ch] : modelCurrAddr[ch];
    expReadNow.data = modelPointer ? word[15:8] : word[7:0];
    modelPointer    = !modelPointer;
  end
  finishRequest();
  waitReadValid();
endtask

task automatic serviceStep(input channelIdT ch);
  logic atTc;
  serviceReq = '{strobe: 1'b1, channel: ch};
  atTc       = modelCurrCount[ch] == '0;
  if (!modelMask[ch])
  begin
    expBusNow = '{valid: 1'b1, addr: modelCurrAddr[ch], tc: atTc};
    if (atTc && modelAutoInit[ch])
    begin
      modelCurrAddr[ch]  = modelBaseAddr[ch];
      modelCurrCount[ch] = modelBaseCount[ch];
    end
    else
    begin
      modelCurrAddr[ch]  = modelDecrement[ch] ? modelCurrAddr[ch] - 16'd1 :
                                                modelCurrAddr[ch] + 16'd1;
      modelCurrCount[ch] = modelCurrCount[ch] - 16'd1;
    end
    if (atTc)
    begin
      modelTc[ch] = 1'b1;
      if (!modelAutoInit[ch])
        modelMask[ch] = 1'b1;
    end
  end
  finishRequest();
endtask

// Low byte first, after clearing the byte pointer
task automatic programChannel(input channelIdT ch, input dmaAddrT addr, input dmaCountT count);
  writeReg(offsetClearPointer, 8'h00);
  writeReg(regOffsetT'(2 * ch), addr[7:0]);
  writeReg(regOffsetT'(2 * ch), addr[15:8]);
  writeReg(regOffsetT'(2 * ch + 1), count[7:0]);
  writeReg(regOffsetT'(2 * ch + 1), count[15:8]);
endtask

task automatic waitQuiet();
  int n;
  n = 0;
  @(negedge dif);
  while ((expReadMid.valid || expReadDue.valid || expBusMid.valid || expBusDue.valid ||
          readRsp.valid || busOut.valid) && n < waitLimit)
  begin
    @(negedge dif);
    n++;
  end
  if (expReadMid.valid || expReadDue.valid || expBusMid.valid || expBusDue.valid ||
      readRsp.valid || busOut.valid)
    stopOnError("Timeout: outputs did not return to idle");
  else
  begin
    @(posedge dif);
    #1;
  end
endtask

// File: testbench/dmaTbTop.sv
// Testbench top: clock, reset, DUT instance, stimulus and output assertions
`timescale 1ns/1ps

module dmaTbTop;
  import dmaPkg::*;

  logic       dif;
  logic       reset;
  hostReqT    hostReq;
  serviceReqT serviceReq;
  readRspT    readRsp;
  busOutT     busOut;

  // Expected responses, two cycles of delay after the request
  readRspT    expReadNow;
  readRspT    expReadMid;
  readRspT    expReadDue;
  busOutT     expBusNow;
  busOutT     expBusMid;
  busOutT     expBusDue;

  int          seed;
  logic [31:0] randValue;

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  `include "dmaTbTasks.svh"

  dmaTop #(
    .NumChannels (numChannels)
  ) u_dmaTop (
    .dif        (dif),
    .reset      (reset),
    .hostReq    (hostReq),
    .serviceReq (serviceReq),
    .readRsp    (readRsp),
    .busOut     (busOut)
  );

  initial
    dif = 1'b0;
  always #4 dif = !dif;

  always @(posedge dif)
  begin
    expReadMid <= expReadNow;
    expReadDue <= expReadMid;
    expBusMid  <= expBusNow;
    expBusDue  <= expBusMid;
  end

  readCheck: assert property (@(posedge dif) disable iff (reset)
    readRsp.valid == expReadDue.valid && (!expReadDue.valid || readRsp.data == expReadDue.data))
    else stopOnError($sformatf("ERR %0t readRsp got %03h expected %03h",
                               $time, $sampled(readRsp), $sampled(expReadDue)));

  busCheck: assert property (@(posedge dif) disable iff (reset)
    busOut.valid == expBusDue.valid && (!expBusDue.valid || busOut == expBusDue))
    else stopOnError($sformatf("ERR %0t busOut got %05h expected %05h",
                               $time, $sampled(busOut), $sampled(expBusDue)));

  initial
  begin
    seed       = 32'hb8f;
    reset      = 1'b1;
    hostReq    = '0;
    serviceReq = '0;
    expReadNow = '0;
    expBusNow  = '0;
    clearModel();
    repeat (8) @(posedge dif);
    #1;
    reset = 1'b0;

    // Random address and count per channel, then read back
    for (int i = 0; i < numChannels; i++)
    begin
      randValue = $random(seed);
      programChannel(channelIdT'(i), randValue[15:0], randValue[31:16]);
    end
    for (int off = 0; off < 2 * numChannels; off++)
    begin
      readReg(regOffsetT'(off));
      readReg(regOffsetT'(off));
    end
    writeReg(offsetMasterClear, 8'h00);
    for (int off = 0; off < 2 * numChannels; off++)
    begin
      readReg(regOffsetT'(off));
      readReg(regOffsetT'(off));
    end

    // Incrementing channel 0 and decrementing channel 1, back to back
    randValue = $random(seed);
    writeReg(offsetMode, 8'h00);
    programChannel(2'd0, randValue[15:0], 16'd10);
    writeReg(offsetMode, 8'h21);
    programChannel(2'd1, randValue[31:16], 16'd10);
    for (int i = 0; i < 4; i++)
      serviceStep(2'd0);
    for (int i = 0; i < 6; i++)
      serviceStep(channelIdT'(i % 2 + 1) - 2'd1);
    waitQuiet();

    // Terminal count with and without auto-initialize
    randValue = $random(seed);
    writeReg(offsetMode, 8'h02);
    programChannel(2'd2, randValue[15:0], 16'd3);
    writeReg(offsetMode, 8'h13);
    programChannel(2'd3, randValue[31:16], 16'd2);
    for (int i = 0; i < 5; i++)
      serviceStep(2'd2);
    for (int i = 0; i < 4; i++)
      serviceStep(2'd3);
    waitQuiet();
    readReg(offsetStatus);
    readReg(offsetStatus);

    // Single mask, all mask and clear mask
    writeReg(offsetSingleMask, 8'h04);
    serviceStep(2'd0);
    serviceStep(2'd1);
    writeReg(offsetClearMask, 8'h00);
    serviceStep(2'd0);
    serviceStep(2'd2);
    writeReg(offsetAllMask, 8'h0f);
    for (int i = 0; i < numChannels; i++)
      serviceStep(channelIdT'(i));
    writeReg(offsetSingleMask, 8'h01);
    for (int i = 0; i < numChannels; i++)
      serviceStep(channelIdT'(i));
    writeReg(offsetClearMask, 8'h00);
    for (int i = 0; i < numChannels; i++)
      serviceStep(channelIdT'(i));
    waitQuiet();
    readReg(offsetStatus);

    $display("All checks passed");
    $finish;
  end

endmodule

// File: dmaRegs.f
+incdir+testbench
hw/dmaPkg.sv
hw/dmaCommandDecoder.sv
hw/dmaChannel.sv
hw/dmaOutputStage.sv
hw/dmaTop.sv
testbench/dmaTbTop.sv
